/* Makefile */
TOP := tb_decoding_graph

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f decoding_graph.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

/* decoding_graph.f */
+incdir+hdl
+incdir+tests
hdl/decoder_pkg.sv
hdl/link_grow_if.sv
hdl/syndrome_stage.sv
hdl/ns_link_array.sv
hdl/ew_link_array.sv
hdl/correction_output.sv
hdl/decoding_graph.sv
tests/tb_decoding_graph.sv

/* hdl/correction_output.sv */
`timescale 1ns/1ns

module correction_output
    import decoder_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    link_grow_if.sink   ns_bus,
    link_grow_if.sink   ew_bus,
    output logic        corr_valid_o,
    input  logic        corr_ready_i,
    output corr_vec_t   correction_o,
    output corr_count_t corr_count_o,
    output logic        result_taken_o
);

    corr_vec_t   merged;
    corr_vec_t   corr_q;
    corr_count_t count_q;
    logic        valid_q;
    logic        load;

    // Number of links marked for correction
    function automatic corr_count_t count_ones(input corr_vec_t vec);
        corr_count_t total;
        total = '0;
        for (int i = 0; i < $bits(corr_vec_t); i++) begin
            total = total + corr_count_t'(vec[i]);
        end
        return total;
    endfunction

    assign merged = {ew_bus.grown, ns_bus.grown};   // EW index range sits above NS
    assign load = ns_bus.grown_valid && ew_bus.grown_valid && !valid_q;
    assign result_taken_o = valid_q && corr_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (result_taken_o) begin
            valid_q <= 1'b0;
        end
    end

    // Result is captured once per round and held under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            corr_q <= merged;
            count_q <= count_ones(merged);
        end
    end

    assign corr_valid_o = valid_q;
    assign correction_o = corr_q;
    assign corr_count_o = count_q;

    a_hold_result: assert property (@(posedge clk) disable iff (reset_i)
        (corr_valid_o && !corr_ready_i) |=> (corr_valid_o && $stable(correction_o)));

endmodule

/* hdl/decoder_pkg.sv */
package decoder_pkg;

`include "decoder_settings.svh"

    localparam int NODE_COUNT = `GRID_X * `GRID_Z;
    localparam int NS_COUNT = (`GRID_X + 1) * `GRID_Z;    // Includes top and bottom rows
    localparam int EW_COUNT = `GRID_X * (`GRID_Z + 1);    // Includes left and right columns
    localparam int CORR_COUNT = NS_COUNT + EW_COUNT;

    // Sequence of one decoding round
    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_MEASURE,
        STAGE_GROW,
        STAGE_REPORT
    } stage_e;

    // Node index is row * GRID_Z + column
    typedef logic [NODE_COUNT-1:0] node_vec_t;

    typedef logic [NS_COUNT-1:0] ns_vec_t;
    typedef logic [EW_COUNT-1:0] ew_vec_t;

    // NS links in the low bits, EW links above them
    typedef logic [CORR_COUNT-1:0] corr_vec_t;

    typedef logic [$clog2(CORR_COUNT + 1)-1:0] corr_count_t;
    typedef logic [$clog2(`MAX_WEIGHT + 1)-1:0] growth_t;

endpackage

/* hdl/decoder_settings.svh */
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// Grid of stabilizer nodes, rows by columns
`define GRID_X 4
`define GRID_Z 3

// Growth needed before a link counts as fully grown
`define LINK_WEIGHT 2
`define BOUNDARY_WEIGHT 1   // Boundary links have one endpoint only

// Growth cycles spent on each round
`define GROW_STEPS 1

// Largest weight in use, sizes the growth counters
`define MAX_WEIGHT 2

`endif

/* hdl/decoding_graph.sv */
`timescale 1ns/1ns
`include "decoder_settings.svh"

module decoding_graph
    import decoder_pkg::*;
(
    input  logic                           clk,
    input  logic                           reset_i,
    input  logic                           meas_valid_i,
    output logic                           meas_ready_o,
    input  logic [`GRID_X*`GRID_Z-1:0]     measurements_i,
    output logic                           corr_valid_o,
    input  logic                           corr_ready_i,
    output logic [$bits(corr_vec_t)-1:0]   correction_o,
    output logic [$bits(corr_count_t)-1:0] corr_count_o
);

    logic result_taken;   // Output transfer, releases the stage FSM

    link_grow_if #(.WIDTH(NS_COUNT)) ns_bus ();
    link_grow_if #(.WIDTH(EW_COUNT)) ew_bus ();

    syndrome_stage i_syndrome_stage (
        .clk            (clk),
        .reset_i        (reset_i),
        .meas_valid_i   (meas_valid_i),
        .meas_ready_o   (meas_ready_o),
        .measurements_i (measurements_i),
        .result_taken_i (result_taken),
        .ns_bus         (ns_bus),
        .ew_bus         (ew_bus)
    );

    // Both link arrays grow side by side
    ns_link_array i_ns_link_array (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (ns_bus)
    );

    ew_link_array i_ew_link_array (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (ew_bus)
    );

    correction_output i_correction_output (
        .clk            (clk),
        .reset_i        (reset_i),
        .ns_bus         (ns_bus),
        .ew_bus         (ew_bus),
        .corr_valid_o   (corr_valid_o),
        .corr_ready_i   (corr_ready_i),
        .correction_o   (correction_o),
        .corr_count_o   (corr_count_o),
        .result_taken_o (result_taken)
    );

endmodule

/* hdl/ew_link_array.sv */
`timescale 1ns/1ns
`include "decoder_settings.svh"

module ew_link_array
    import decoder_pkg::*;
(
    input logic        clk,
    input logic        reset_i,
    link_grow_if.links bus
);

    localparam int GW = $bits(growth_t);

    ew_vec_t grown_vec;

    // Link (r, c) joins node (r, c-1) and node (r, c)
    for (genvar r = 0; r < `GRID_X; r++) begin : g_row
        for (genvar c = 0; c <= `GRID_Z; c++) begin : g_col
            localparam bit BOUNDARY = (c == 0) || (c == `GRID_Z);
            localparam growth_t WEIGHT = BOUNDARY ? growth_t'(`BOUNDARY_WEIGHT)
                                                  : growth_t'(`LINK_WEIGHT);
            logic        west_def;
            logic        east_def;
            logic [1:0]  ends;
            logic [GW:0] sum;      // One bit wider to catch overshoot
            growth_t     cnt_q;

            if (c > 0) begin : g_west
                assign west_def = bus.defects[r * `GRID_Z + c - 1];
            end else begin : g_left
                assign west_def = 1'b0;
            end

            if (c < `GRID_Z) begin : g_east
                assign east_def = bus.defects[r * `GRID_Z + c];
            end else begin : g_right
                assign east_def = 1'b0;
            end

            assign ends = {1'b0, west_def} + {1'b0, east_def};
            assign sum = {1'b0, cnt_q} + (GW + 1)'(ends);

            always_ff @(posedge clk) begin
                if (reset_i || bus.stage == STAGE_MEASURE) begin
                    cnt_q <= '0;
                end else if (bus.stage == STAGE_GROW) begin
                    if (sum >= {1'b0, WEIGHT}) begin
                        cnt_q <= WEIGHT;
                    end else begin
                        cnt_q <= sum[GW-1:0];
                    end
                end
            end

            assign grown_vec[r * (`GRID_Z + 1) + c] = (cnt_q == WEIGHT);

            a_cnt_max: assert property (@(posedge clk) disable iff (reset_i)
                cnt_q <= growth_t'(`MAX_WEIGHT));
        end
    end

    assign bus.grown = grown_vec;
    assign bus.grown_valid = (bus.stage == STAGE_REPORT);   // Counters hold in REPORT

endmodule

/* hdl/link_grow_if.sv */
`timescale 1ns/1ns

// Stage control and defects out to one link array, grown flags back
interface link_grow_if
    import decoder_pkg::*;
#(
    parameter int WIDTH = 1
);

    stage_e           stage;
    node_vec_t        defects;      // Changed nodes of the current round
    logic [WIDTH-1:0] grown;        // One flag per link
    logic             grown_valid;

    modport ctrl (
        output stage,
        output defects
    );

    modport links (
        input  stage,
        input  defects,
        output grown,
        output grown_valid
    );

    modport sink (
        input grown,
        input grown_valid
    );

endinterface

/* hdl/ns_link_array.sv */
`timescale 1ns/1ns
`include "decoder_settings.svh"

module ns_link_array
    import decoder_pkg::*;
(
    input logic        clk,
    input logic        reset_i,
    link_grow_if.links bus
);

    localparam int GW = $bits(growth_t);

    ns_vec_t grown_vec;

    // Link (r, c) joins node (r-1, c) and node (r, c)
    for (genvar r = 0; r <= `GRID_X; r++) begin : g_row
        for (genvar c = 0; c < `GRID_Z; c++) begin : g_col
            localparam bit BOUNDARY = (r == 0) || (r == `GRID_X);
            localparam growth_t WEIGHT = BOUNDARY ? growth_t'(`BOUNDARY_WEIGHT)
                                                  : growth_t'(`LINK_WEIGHT);
            logic        north_def;
            logic        south_def;
            logic [1:0]  ends;     // Defect endpoints of this link
            logic [GW:0] sum;
            growth_t     cnt_q;

            if (r > 0) begin : g_north
                assign north_def = bus.defects[(r - 1) * `GRID_Z + c];
            end else begin : g_top
                assign north_def = 1'b0;
            end

            if (r < `GRID_X) begin : g_south
                assign south_def = bus.defects[r * `GRID_Z + c];
            end else begin : g_bottom
                assign south_def = 1'b0;
            end

            assign ends = {1'b0, north_def} + {1'b0, south_def};
            assign sum = {1'b0, cnt_q} + (GW + 1)'(ends);

            always_ff @(posedge clk) begin
                if (reset_i || bus.stage == STAGE_MEASURE) begin
                    cnt_q <= '0;
                end else if (bus.stage == STAGE_GROW) begin
                    if (sum >= {1'b0, WEIGHT}) begin
                        cnt_q <= WEIGHT;    // Saturate at the link weight
                    end else begin
                        cnt_q <= sum[GW-1:0];
                    end
                end
            end

            assign grown_vec[r * `GRID_Z + c] = (cnt_q == WEIGHT);

            a_cnt_max: assert property (@(posedge clk) disable iff (reset_i)
                cnt_q <= growth_t'(`MAX_WEIGHT));
        end
    end

    assign bus.grown = grown_vec;
    assign bus.grown_valid = (bus.stage == STAGE_REPORT);

endmodule

/* hdl/syndrome_stage.sv */
`timescale 1ns/1ns
`include "decoder_settings.svh"

module syndrome_stage
    import decoder_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      meas_valid_i,
    output logic      meas_ready_o,
    input  node_vec_t measurements_i,
    input  logic      result_taken_i,
    link_grow_if.ctrl ns_bus,
    link_grow_if.ctrl ew_bus
);

    localparam int STEP_W = $clog2(`GROW_STEPS + 1);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`GROW_STEPS - 1);

    stage_e            state_q;
    node_vec_t         prev_meas_q;    // Last accepted round
    node_vec_t         defects_q;
    logic [STEP_W-1:0] step_q;         // Growth cycles done so far
    logic              accept;

    assign meas_ready_o = (state_q == STAGE_IDLE);
    assign accept = meas_valid_i && meas_ready_o;

    // Round sequencing, one round in flight
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= STAGE_IDLE;
            prev_meas_q <= '0;
            step_q <= '0;
        end else begin
            case (state_q)
                STAGE_IDLE: begin
                    if (accept) begin
                        prev_meas_q <= measurements_i;
                        state_q <= STAGE_MEASURE;
                    end
                end
                STAGE_MEASURE: begin
                    step_q <= '0;    // Arrays clear their counters here
                    state_q <= STAGE_GROW;
                end
                STAGE_GROW: begin
                    if (step_q == LAST_STEP) begin
                        state_q <= STAGE_REPORT;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                STAGE_REPORT: begin
                    // Hold until the result has left the output stage
                    if (result_taken_i) begin
                        state_q <= STAGE_IDLE;
                    end
                end
                default: state_q <= STAGE_IDLE;
            endcase
        end
    end

    // A defect is a node whose measurement flipped since the last round
    always_ff @(posedge clk) begin
        if (accept) begin
            defects_q <= measurements_i ^ prev_meas_q;
        end
    end

    assign ns_bus.stage = state_q;
    assign ns_bus.defects = defects_q;
    assign ew_bus.stage = state_q;
    assign ew_bus.defects = defects_q;

    // Only the round waiting in REPORT can have its result taken
    a_report_hold: assert property (@(posedge clk) disable iff (reset_i)
        result_taken_i |-> state_q == STAGE_REPORT);

endmodule

/* tests/tb_decoding_graph_tasks.svh */
`ifndef TB_DECODING_GRAPH_TASKS_SVH
`define TB_DECODING_GRAPH_TASKS_SVH

// Offers one round and returns on its transfer edge
task automatic send_round(input node_vec_t meas);
    int waited;
    waited = 0;
    @(posedge clk);
    meas_valid_i <= 1'b1;
    measurements_i <= meas;
    @(negedge clk);
    while (!meas_ready_o && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (!meas_ready_o) begin
        report_failure("meas_ready_o never rose for a new round");
    end
    @(posedge clk);
    meas_valid_i <= 1'b0;
    exp_corr = model_correction(meas ^ model_prev);
    exp_count = count_set(exp_corr);
    model_prev = meas;
    round_count++;
endtask

// Waits for corr_valid_o and checks latency and result against the model
task automatic wait_result();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!corr_valid_o && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
    end
    if (!corr_valid_o) begin
        report_failure("timed out waiting for corr_valid_o");
    end else begin
        if (cycles != LATENCY) begin
            report_failure($sformatf("corr_valid_o rose %0d cycles after the transfer, not %0d",
                                     cycles, LATENCY));
        end
        if (correction_o !== exp_corr) begin
            report_mismatch("correction_o", 64'(correction_o), 64'(exp_corr));
        end
        if (corr_count_o !== exp_count) begin
            report_mismatch("corr_count_o", 64'(corr_count_o), 64'(exp_count));
        end
    end
endtask

task automatic wait_taken();
    int waited;
    waited = 0;
    @(negedge clk);
    while (corr_valid_o && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (corr_valid_o) begin
        report_failure("corr_valid_o stayed high while corr_ready_i was high");
    end
endtask

task automatic run_round(input node_vec_t meas);
    send_round(meas);
    wait_result();
    wait_taken();
endtask

// The round is chosen so that exactly these nodes flip
task automatic send_defects(input node_vec_t defects);
    run_round(model_prev ^ defects);
endtask

task automatic test_reset_state();
    @(negedge clk);
    if (meas_ready_o !== 1'b1) begin
        report_mismatch("meas_ready_o", 64'(meas_ready_o), 64'h1);
    end
    if (corr_valid_o !== 1'b0) begin
        report_mismatch("corr_valid_o", 64'(corr_valid_o), 64'h0);
    end
endtask

task automatic test_adjacent_pair();
    node_vec_t defects;
    corr_vec_t want;
    defects = '0;
    defects[1 * `GRID_Z + 1] = 1'b1;
    defects[2 * `GRID_Z + 1] = 1'b1;
    want = '0;
    want[2 * `GRID_Z + 1] = 1'b1;    // NS link between rows 1 and 2
    send_defects(defects);
    if (correction_o !== want) begin
        report_mismatch("correction_o", 64'(correction_o), 64'(want));
    end
    if (corr_count_o !== corr_count_t'(1)) begin
        report_mismatch("corr_count_o", 64'(corr_count_o), 64'h1);
    end

    defects = '0;
    defects[1 * `GRID_Z + 1] = 1'b1;   // Lone interior defect, no link reaches its weight
    send_defects(defects);
    if (correction_o !== '0) begin
        report_mismatch("correction_o", 64'(correction_o), 64'h0);
    end
    if (corr_count_o !== '0) begin
        report_mismatch("corr_count_o", 64'(corr_count_o), 64'h0);
    end
endtask

task automatic test_corner_defect();
    node_vec_t defects;
    corr_vec_t want;
    defects = '0;
    defects[0] = 1'b1;
    want = '0;
    want[0] = 1'b1;           // Top boundary NS link
    want[NS_COUNT] = 1'b1;    // Left boundary EW link
    send_defects(defects);
    if (correction_o !== want) begin
        report_mismatch("correction_o", 64'(correction_o), 64'(want));
    end
    if (corr_count_o !== corr_count_t'(2)) begin
        report_mismatch("corr_count_o", 64'(corr_count_o), 64'h2);
    end
endtask

task automatic test_repeated_round();
    node_vec_t meas;
    meas = node_vec_t'(32'h5a3c_96e1);
    run_round(meas);
    run_round(meas);
    if (correction_o !== '0) begin
        report_mismatch("correction_o", 64'(correction_o), 64'h0);
    end
    if (corr_count_o !== '0) begin
        report_mismatch("corr_count_o", 64'(corr_count_o), 64'h0);
    end
endtask

task automatic test_back_pressure();
    node_vec_t   defects;
    corr_vec_t   held;
    corr_count_t held_count;
    int          waited;
    defects = '0;
    defects[0] = 1'b1;
    defects[`GRID_X * `GRID_Z - 1] = 1'b1;   // Opposite corners
    @(posedge clk);
    corr_ready_i <= 1'b0;
    send_round(model_prev ^ defects);
    wait_result();
    held = correction_o;
    held_count = corr_count_o;
    @(posedge clk);
    meas_valid_i <= 1'b1;                    // Competing round must wait for the transfer
    measurements_i <= ~model_prev;
    repeat (10) begin
        @(negedge clk);
        if (correction_o !== held) begin
            report_mismatch("correction_o", 64'(correction_o), 64'(held));
        end
        if (corr_count_o !== held_count) begin
            report_mismatch("corr_count_o", 64'(corr_count_o), 64'(held_count));
        end
        if (corr_valid_o !== 1'b1) begin
            report_mismatch("corr_valid_o", 64'(corr_valid_o), 64'h1);
        end
        if (meas_ready_o !== 1'b0) begin
            report_mismatch("meas_ready_o", 64'(meas_ready_o), 64'h0);
        end
    end
    @(posedge clk);
    meas_valid_i <= 1'b0;
    corr_ready_i <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!meas_ready_o && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
    end
    if (!meas_ready_o) begin
        report_failure("meas_ready_o did not rise after the held result was taken");
    end
    if (corr_valid_o !== 1'b0) begin
        report_mismatch("corr_valid_o", 64'(corr_valid_o), 64'h0);
    end
endtask

task automatic test_random_rounds();
    node_vec_t meas;
    for (int i = 0; i < 20; i++) begin
        meas = node_vec_t'($random(seed));
        run_round(meas);
    end
endtask

`endif

/* tests/tb_decoding_graph.sv */
`timescale 1ns/1ns
`include "decoder_settings.svh"

module tb_decoding_graph import decoder_pkg::*;;

    localparam int TIMEOUT = 50;                  // Cycles any single wait may take
    localparam int LATENCY = `GROW_STEPS + 2;     // Transfer edge to corr_valid_o

    logic        clk;
    logic        reset_i;
    logic        meas_valid_i;
    logic        meas_ready_o;
    node_vec_t   measurements_i;
    logic        corr_valid_o;
    logic        corr_ready_i;
    corr_vec_t   correction_o;
    corr_count_t corr_count_o;

    int          error_count;
    int          round_count;
    integer      seed;
    node_vec_t   model_prev;    // Reference copy of the previous round
    corr_vec_t   exp_corr;      // Expected result of the round in flight
    corr_count_t exp_count;

    decoding_graph i_decoding_graph (
        .clk            (clk),
        .reset_i        (reset_i),
        .meas_valid_i   (meas_valid_i),
        .meas_ready_o   (meas_ready_o),
        .measurements_i (measurements_i),
        .corr_valid_o   (corr_valid_o),
        .corr_ready_i   (corr_ready_i),
        .correction_o   (correction_o),
        .corr_count_o   (corr_count_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // One link after all growth cycles, set once growth reaches the weight
    function automatic logic link_grown(input int ends, input bit boundary);
        int weight;
        int growth;
        weight = boundary ? `BOUNDARY_WEIGHT : `LINK_WEIGHT;
        growth = `GROW_STEPS * ends;
        if (growth > weight) begin
            growth = weight;
        end
        return (ends > 0) && (growth == weight);
    endfunction

    // Expected correction vector for one set of defects
    function automatic corr_vec_t model_correction(input node_vec_t defects);
        corr_vec_t corr;
        int        ends;
        corr = '0;
        for (int r = 0; r <= `GRID_X; r++) begin
            for (int c = 0; c < `GRID_Z; c++) begin
                ends = 0;
                if (r > 0) begin
                    ends += int'(defects[(r - 1) * `GRID_Z + c]);
                end
                if (r < `GRID_X) begin
                    ends += int'(defects[r * `GRID_Z + c]);
                end
                corr[r * `GRID_Z + c] = link_grown(ends, (r == 0) || (r == `GRID_X));
            end
        end
        for (int r = 0; r < `GRID_X; r++) begin
            for (int c = 0; c <= `GRID_Z; c++) begin
                ends = 0;
                if (c > 0) begin
                    ends += int'(defects[r * `GRID_Z + c - 1]);
                end
                if (c < `GRID_Z) begin
                    ends += int'(defects[r * `GRID_Z + c]);
                end
                corr[NS_COUNT + r * (`GRID_Z + 1) + c] =
                    link_grown(ends, (c == 0) || (c == `GRID_Z));
            end
        end
        return corr;
    endfunction

    function automatic corr_count_t count_set(input corr_vec_t corr);
        int total;
        total = 0;
        for (int i = 0; i < CORR_COUNT; i++) begin
            total += int'(corr[i]);
        end
        return corr_count_t'(total);
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        error_count++;
        $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

`include "tb_decoding_graph_tasks.svh"

    initial begin
        error_count = 0;
        round_count = 0;
        seed = 44;
        model_prev = '0;
        exp_corr = '0;
        exp_count = '0;
        reset_i = 1'b1;
        meas_valid_i = 1'b0;
        measurements_i = '0;
        corr_ready_i = 1'b1;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        test_reset_state();
        test_adjacent_pair();
        test_corner_defect();
        test_repeated_round();
        test_back_pressure();
        test_random_rounds();

        repeat (2) @(posedge clk);
        $display("Rounds: %0d, errors: %0d", round_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Last guard in case a wait loop never returns
    initial begin
        #20000;
        $display("Simulation ran past its time limit");
        $display("Done: errors found");
        $finish;
    end

endmodule
